/* bench/serdes_drive_chk.sv */
//////////////////////////////////////////////////
// frame serializer checks
// line idle, single take pulses, twelve-cycle frames
//////////////////////////////////////////////////

`timescale 1ns/10ps

module serdes_drive_chk (
	input logic clock,
	input logic reset,
	input logic take,
	input logic serial,
	input logic in_frame,
	input logic frame_done
);

	localparam int fb = serdes_link_pkg::frame_bits;

	// failed assertions seen so far
	int error_count = 0;

	// line low outside a frame
	idle_line_low: assert property (
		@(posedge clock) disable iff (reset) !in_frame |-> !serial
	) else begin
		error_count++;
		$error("serial is high while no frame is on the line");
	end

	// one take per frame start
	take_single: assert property (
		@(posedge clock) disable iff (reset) take |=> !take
	) else begin
		error_count++;
		$error("take held high for two cycles");
	end

	// stop bit lands twelve cycles after the start
	frame_length: assert property (
		@(posedge clock) disable iff (reset) take |-> ##fb frame_done
	) else begin
		error_count++;
		$error("stop bit missing twelve cycles after a frame start");
	end

	// and never anywhere else
	stop_after_start: assert property (
		@(posedge clock) disable iff (reset) frame_done |-> $past(take, fb)
	) else begin
		error_count++;
		$error("stop bit without a frame start twelve cycles before");
	end

endmodule

bind frame_serializer serdes_drive_chk frame_check_i (
	.clock      (clock),
	.reset      (reset),
	.take       (take),
	.serial     (serial),
	.in_frame   (in_frame),
	.frame_done (frame_done)
);

/* bench/serdes_drive_tb.sv */
//////////////////////////////////////////////////
// serdes drive testbench
// sends prbs frames through the link, deserializes the line
// and checks words, timing and status against the vector file
//////////////////////////////////////////////////

`timescale 1ns/10ps

module serdes_drive_tb;

	localparam int hold_cycles  = 200;
	localparam int prbs_width   = 64;
	localparam int clock_period = 40;
	localparam int fb           = serdes_link_pkg::frame_bits;
	localparam int dw           = serdes_link_pkg::data_width;
	// frames sent before the mid-run reset
	localparam int first_run    = 5;
	// longest idle gap when run is dropped
	localparam int max_gap      = 8;

	logic clock = 1'b0;
	logic reset;
	logic run;
	logic serial;
	serdes_link_pkg::link_status_t status;

	// vector file contents
	int hold_len;
	int frame_total;
	serdes_link_pkg::ser_word_t expected_words[$];
	bit gap_flags[$];
	int gap_lens[$];
	int gap_total;

	// watchdog limit in cycles, zero until armed
	longint timeout_cycles = 0;

	serdes_drive_top #(
		.PRBS_WIDTH  (prbs_width),
		.HOLD_CYCLES (hold_cycles)
	) serdes_drive_top_i (
		.clock  (clock),
		.reset  (reset),
		.run    (run),
		.serial (serial),
		.status (status)
	);

	always #(clock_period / 2) clock = ~clock;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input serdes_link_pkg::ser_word_t expected,
			input serdes_link_pkg::ser_word_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected.data, actual.data));
		end
	endtask

	task automatic check_status(input string name, input serdes_link_pkg::link_status_t expected,
			input serdes_link_pkg::link_status_t actual);
		if (actual !== expected) begin
			report_failure($sformatf({"Mismatch in %s: expected ready %b in_frame %b count %0d,",
				" actual ready %b in_frame %b count %0d"},
				name, expected.link_ready, expected.in_frame, expected.frame_count,
				actual.link_ready, actual.in_frame, actual.frame_count));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch in %s: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	// one clock, outputs read on the falling edge where they are stable
	task automatic step_cycle();
		@(posedge clock);
		@(negedge clock);
	endtask

	// lines starting with # are comments
	task automatic read_vectors();
		int fd;
		int field;
		int value;
		int flag;
		logic [31:0] word;
		string line;
		serdes_link_pkg::ser_word_t entry;
		fd = $fopen("bench/serdes_vectors.txt", "r");
		if (fd == 0) begin
			report_failure("Cannot open the vector file bench/serdes_vectors.txt");
		end
		field = 0;
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 0 && line.getc(0) != "#") begin
				if (field == 0) begin
					if ($sscanf(line, "%d", value) == 1) begin
						hold_len = value;
						field = 1;
					end
				end else if (field == 1) begin
					if ($sscanf(line, "%d", value) == 1) begin
						frame_total = value;
						field = 2;
					end
				end else if ($sscanf(line, "%h %d", word, flag) == 2) begin
					entry.data = word[dw-1:0];
					expected_words.push_back(entry);
					gap_flags.push_back(flag != 0);
				end
			end
		end
		$fclose(fd);
		if (field != 2 || expected_words.size() != frame_total || frame_total <= first_run) begin
			report_failure("The vector file is incomplete or its frame count is wrong");
		end
	endtask

	// reset for three cycles, status and line must sit at their reset values
	task automatic apply_reset(input string name);
		serdes_link_pkg::link_status_t expected;
		expected = '0;
		reset = 1'b1;
		run   = 1'b0;
		repeat (3) begin
			step_cycle();
			check_status({name, " status"}, expected, status);
			check_bit({name, " line"}, 1'b0, serial);
		end
		reset = 1'b0;
	endtask

	// link stays down for exactly the hold length, then comes up
	task automatic check_hold(input string name);
		serdes_link_pkg::link_status_t expected;
		expected = '0;
		for (int i = 1; i <= hold_len; i++) begin
			step_cycle();
			check_status($sformatf("%s cycle %0d", name, i), expected, status);
			check_bit($sformatf("%s line %0d", name, i), 1'b0, serial);
		end
		step_cycle();
		expected.link_ready = 1'b1;
		check_status({name, " end"}, expected, status);
	endtask

	// deserializer, one line sample per clock
	// while idle the line must carry a start bit exactly when run was applied
	task automatic run_frames(input string name, input int count, input logic run_after);
		int received;
		int bit_pos;
		int gap_left;
		bit status_due;
		bit done;
		logic run_applied;
		logic line;
		logic [dw-1:0] data;
		serdes_link_pkg::ser_word_t got;
		serdes_link_pkg::link_status_t expected;
		received = 0;
		bit_pos = 0;
		gap_left = 0;
		status_due = 0;
		done = 0;
		data = '0;
		run = 1'b1;
		run_applied = 1'b1;
		while (!done) begin
			step_cycle();
			line = serial;
			// frame_count moves one clock after the stop bit
			if (status_due) begin
				expected.link_ready  = 1'b1;
				expected.in_frame    = run_applied;
				expected.frame_count = 16'(received);
				check_status($sformatf("%s status after frame %0d", name, received),
					expected, status);
				status_due = 0;
				done = (received == count);
			end
			if (!done) begin
				if (bit_pos == 0) begin
					check_bit($sformatf("%s idle or start before frame %0d", name, received),
						run_applied, line);
					if (line) begin
						bit_pos = 1;
						data = '0;
						// drop run mid-frame, the frame must still finish
						if (gap_flags[received]) begin
							run = 1'b0;
							gap_left = gap_lens[received];
						end
					end else if (gap_left > 0) begin
						gap_left--;
						if (gap_left == 0) begin
							run = 1'b1;
						end
					end
				end else if (bit_pos <= dw) begin
					data[bit_pos - 1] = line;
					bit_pos++;
				end else begin
					check_bit($sformatf("%s stop bit of frame %0d", name, received), 1'b0, line);
					got.data = data;
					check_word($sformatf("%s frame %0d", name, received),
						expected_words[received], got);
					received++;
					status_due = 1;
					bit_pos = 0;
					if (received == count) begin
						run = run_after;
					end
				end
			end
			run_applied = run;
		end
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		void'($urandom(11));
		read_vectors();
		// gap lengths drawn up front so the watchdog can budget for them
		gap_total = 0;
		for (int k = 0; k < frame_total; k++) begin
			gap_lens.push_back(int'($urandom % max_gap) + 1);
			if (gap_flags[k]) begin
				gap_total += gap_lens[k];
			end
		end
		timeout_cycles = longint'(2 * (3 + hold_len + 1) + fb * (first_run + frame_total + 4)
			+ 2 * gap_total + 100);

		apply_reset("power-up reset");
		check_hold("power-up hold");
		run_frames("first run", first_run, 1'b1);
		// next frame has started, cut it short
		repeat (4) step_cycle();
		apply_reset("mid-run reset");
		check_hold("hold after reset");
		run_frames("second run", frame_total, 1'b0);
		repeat (2 * fb) begin
			step_cycle();
			check_bit("line after run dropped", 1'b0, serial);
		end

		if (serdes_drive_top_i.frame_serializer_i.frame_check_i.error_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			report_failure("Bound assertions on the frame rules failed during the run");
		end
	end

	// watchdog
	initial begin
		wait (timeout_cycles > 0);
		#(timeout_cycles * clock_period);
		report_failure("Watchdog expired, the run did not finish in time");
	end

endmodule

/* bench/serdes_vectors.txt */
# line 1: power-on hold length in clocks, line 2: number of frames
# then one frame per line: expected data word (hex), gap flag (1 drops run for a random gap)
200
30
247 0
323 0
391 1
3C8 0
1E4 0
0F2 0
279 0
13C 1
09E 0
24F 0
327 0
393 1
3C9 0
1E4 0
0F2 0
279 0
33C 1
19E 0
2CF 0
367 0
1B3 0
2D9 0
16C 1
2B6 0
15B 0
2AD 0
356 0
1AB 1
2D5 0
16A 0

/* rtl/frame_serializer.sv */
//////////////////////////////////////////////////
// frame serializer
// wraps each word in start and stop bits, shifts lsb first
//////////////////////////////////////////////////

`timescale 1ns/10ps

module frame_serializer (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       link_ready,
	input  logic                       run,
	input  serdes_link_pkg::ser_word_t next_word,
	output logic                       take,
	output logic                       serial,
	output logic                       in_frame,
	output logic                       frame_done
);

	localparam int fb    = serdes_link_pkg::frame_bits;
	localparam int cnt_w = $clog2(fb);

	// index of the stop bit inside a frame
	localparam logic [cnt_w-1:0] last_bit = cnt_w'(fb - 1);

	// bit position of the bit now on the line
	logic [cnt_w-1:0] bit_count;

	// frame image, bit 0 is on the line
	logic [fb-1:0] shifter;

	// stop bit is on the line this cycle
	assign frame_done = in_frame && (bit_count == last_bit);

	// start a frame from idle or straight after a stop bit
	// one pulse per frame, the capture stage reloads on it
	assign take = link_ready && run && (!in_frame || frame_done);

	// the shifter empties to zero after the stop bit
	// so the idle line needs no extra gating
	assign serial = shifter[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			shifter   <= '0;
			bit_count <= '0;
			in_frame  <= 1'b0;
		end else if (take) begin
			// stop, data lsb at bit 1, start at bit 0
			shifter   <= {1'b0, next_word.data, 1'b1};
			bit_count <= '0;
			in_frame  <= 1'b1;
		end else begin
			// shift towards bit 0, zeros fill from the top
			shifter <= {1'b0, shifter[fb-1:1]};
			if (frame_done) begin
				// run dropped, go idle after the stop bit
				bit_count <= '0;
				in_frame  <= 1'b0;
			end else if (in_frame) begin
				bit_count <= bit_count + 1'b1;
			end
		end
	end

	// a frame in progress is never cut short by run
	// only reset can abort it

endmodule

/* rtl/power_on_hold.sv */
//////////////////////////////////////////////////
// power-on hold
// keeps the link quiet for HOLD_CYCLES clocks after reset
//////////////////////////////////////////////////

`timescale 1ns/10ps

module power_on_hold #(
	parameter int HOLD_CYCLES = 1024
) (
	input  logic clock,
	input  logic reset,
	output logic link_ready
);

	// counter must be able to hold HOLD_CYCLES itself
	localparam int cnt_w = $clog2(HOLD_CYCLES + 1);

	logic [cnt_w-1:0] hold_count;

	// count clocks until the limit, then latch ready
	// ready stays up until the next reset
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_count <= '0;
			link_ready <= 1'b0;
		end else if (!link_ready) begin
			if (hold_count == cnt_w'(HOLD_CYCLES)) begin
				link_ready <= 1'b1;
			end else begin
				hold_count <= hold_count + 1'b1;
			end
		end
	end

endmodule

/* rtl/prbs_gen.sv */
//////////////////////////////////////////////////
// prbs generator
// galois lfsr of parameter width, steps on advance
//////////////////////////////////////////////////

`timescale 1ns/10ps

module prbs_gen #(
	parameter int PRBS_WIDTH = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  advance,
	output logic [PRBS_WIDTH-1:0] state
);

	// full 64-bit mask and seed from the package
	localparam logic [63:0] taps_full = serdes_link_pkg::prbs_taps(PRBS_WIDTH);
	localparam logic [63:0] seed_full = serdes_link_pkg::prbs_seed;

	// trimmed to this generator's width
	localparam logic [PRBS_WIDTH-1:0] taps = taps_full[PRBS_WIDTH-1:0];
	localparam logic [PRBS_WIDTH-1:0] seed = seed_full[PRBS_WIDTH-1:0];

	// next value of the register
	logic [PRBS_WIDTH-1:0] state_next;

	// shift right, fold the dropped bit back in through the taps
	always_comb begin
		state_next = state >> 1;
		if (state[0]) begin
			state_next = state_next ^ taps;
		end
	end

	// load the seed on reset, otherwise step only when asked
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= seed;
		end else if (advance) begin
			state <= state_next;
		end
	end

	// state holds while advance is low
	// a zero seed or zero taps would lock the sequence
	// both come from the package and are nonzero for 32 and 64

endmodule

/* rtl/serdes_drive_top.sv */
//////////////////////////////////////////////////
// serdes drive top
// prbs words framed onto one serial line, with link status
//////////////////////////////////////////////////

`timescale 1ns/10ps

module serdes_drive_top #(
	parameter int PRBS_WIDTH  = 64,
	parameter int HOLD_CYCLES = 1024
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          run,
	output logic                          serial,
	output serdes_link_pkg::link_status_t status
);

	logic                       link_ready;
	logic                       take;
	logic                       advance;
	logic                       in_frame;
	logic                       frame_done;
	logic [PRBS_WIDTH-1:0]      prbs_state;
	serdes_link_pkg::ser_word_t next_word;

	// frames completed since reset
	logic [15:0] frame_count;

	// hold traffic off the line until the far end settles
	power_on_hold #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) power_on_hold_i (
		.clock      (clock),
		.reset      (reset),
		.link_ready (link_ready)
	);

	prbs_gen #(
		.PRBS_WIDTH(PRBS_WIDTH)
	) prbs_gen_i (
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.state   (prbs_state)
	);

	word_capture #(
		.PRBS_WIDTH(PRBS_WIDTH)
	) word_capture_i (
		.clock     (clock),
		.reset     (reset),
		.take      (take),
		.state     (prbs_state),
		.advance   (advance),
		.next_word (next_word)
	);

	frame_serializer frame_serializer_i (
		.clock      (clock),
		.reset      (reset),
		.link_ready (link_ready),
		.run        (run),
		.next_word  (next_word),
		.take       (take),
		.serial     (serial),
		.in_frame   (in_frame),
		.frame_done (frame_done)
	);

	// counts on the stop bit, wraps at 16 bits
	always_ff @(posedge clock) begin
		if (reset) begin
			frame_count <= '0;
		end else if (frame_done) begin
			frame_count <= frame_count + 1'b1;
		end
	end

	assign status.link_ready  = link_ready;
	assign status.in_frame    = in_frame;
	assign status.frame_count = frame_count;

endmodule

/* rtl/serdes_link_pkg.sv */
//////////////////////////////////////////////////
// serdes link package
// frame constants, prbs taps and seed, link structs
//////////////////////////////////////////////////

package serdes_link_pkg;

	// width of one serializer data word
	localparam int data_width = 10;

	// start bit, ten data bits, stop bit
	localparam int frame_bits = data_width + 2;

	// galois feedback mask for a right shifting lfsr
	// 64: x^64 + x^63 + x^61 + x^60 + 1
	// 32: x^32 + x^22 + x^2 + x^1 + 1
	function automatic logic [63:0] prbs_taps(input int unsigned width);
		case (width)
			32: return 64'h0000_0000_8020_0003;
			64: return 64'hD800_0000_0000_0000;
			// unsupported width, no feedback
			default: return '0;
		endcase
	endfunction

	// reset value of the lfsr, narrower widths keep the low bits
	// low 32 bits are nonzero as well
	localparam logic [63:0] prbs_seed = 64'hACE1_0F2D_5B3C_9E47;

	// one data word as it goes to the serializer
	typedef struct packed {
		logic [data_width-1:0] data;
	} ser_word_t;

	// link status seen from outside
	typedef struct packed {
		// power-on hold has expired
		logic link_ready;
		// a frame is on the line
		logic in_frame;
		// frames completed since reset, wraps
		logic [15:0] frame_count;
	} link_status_t;

endpackage

/* rtl/word_capture.sv */
//////////////////////////////////////////////////
// word capture
// buffers the prbs state and offers its low bits as the next word
//////////////////////////////////////////////////

`timescale 1ns/10ps

module word_capture #(
	parameter int PRBS_WIDTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          take,
	input  logic [PRBS_WIDTH-1:0]         state,
	output logic                          advance,
	output serdes_link_pkg::ser_word_t    next_word
);

	localparam logic [63:0] seed_full = serdes_link_pkg::prbs_seed;

	// copy of the generator state, same reset value as the lfsr
	logic [PRBS_WIDTH-1:0] buffered_state;

	// set for one clock after a take
	logic reload;

	// generator steps on the same edge the word is consumed
	assign advance = take;

	// buffer picks up the stepped state once the generator has moved
	// so the buffer always matches the lfsr state at the next take
	always_ff @(posedge clock) begin
		if (reset) begin
			reload         <= 1'b0;
			buffered_state <= seed_full[PRBS_WIDTH-1:0];
		end else begin
			reload <= take;
			if (reload) begin
				buffered_state <= state;
			end
		end
	end

	// only the low ten bits go on the wire
	assign next_word.data = buffered_state[serdes_link_pkg::data_width-1:0];

endmodule

/* run.sh */
#!/bin/sh
# build the serdes drive testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f sources.f \
	--top-module serdes_drive_tb \
	-Mdir obj_dir \
	-o serdes_drive_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/serdes_drive_sim)
sim_status=$?
printf '%s\n' "$output"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi

/* sources.f */
rtl/serdes_link_pkg.sv
rtl/power_on_hold.sv
rtl/prbs_gen.sv
rtl/word_capture.sv
rtl/frame_serializer.sv
rtl/serdes_drive_top.sv
bench/serdes_drive_chk.sv
bench/serdes_drive_tb.sv
